/* rtl/csr_pkg.sv */
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;

    // CSR numbers
    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_BADV   = 14'h007;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    // Field positions in the 32-bit word
    localparam int CRMD_PLV_LO    = 0;
    localparam int CRMD_PLV_HI    = 1;
    localparam int CRMD_IE        = 2;
    localparam int CRMD_DA        = 3;
    localparam int CRMD_PG        = 4;
    localparam int CRMD_DATF_LO   = 5;
    localparam int CRMD_DATF_HI   = 6;
    localparam int CRMD_DATM_LO   = 7;
    localparam int CRMD_DATM_HI   = 8;
    localparam int PRMD_PPLV_LO   = 0;
    localparam int PRMD_PPLV_HI   = 1;
    localparam int PRMD_PIE       = 2;
    localparam int ECFG_LIE_HI    = 12;
    localparam int ESTAT_ECODE_LO = 16;
    localparam int ESTAT_ECODE_HI = 21;
    localparam int ESTAT_ESUB_LO  = 22;
    localparam int ESTAT_ESUB_HI  = 30;
    localparam int EENTRY_VA_LO   = 6;
    localparam int EENTRY_VA_HI   = 31;
    localparam int TCFG_EN        = 0;
    localparam int TCFG_PERIODIC  = 1;
    localparam int TCFG_INITV_LO  = 2;
    localparam int TCFG_INITV_HI  = 31;
    localparam int TICLR_CLR      = 0;

    // Interrupt vector bits
    localparam int IS_SW_HI = 1;
    localparam int IS_HW_LO = 2;
    localparam int IS_HW_HI = 9;
    localparam int IS_TIMER = 11;
    localparam int IS_IPI   = 12;

    // Bit 10 of LIE is reserved
    localparam int_vec_t ECFG_LIE_MASK = 13'h1bff;

    localparam ecode_t    ECODE_ADE     = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam esubcode_t ESUBCODE_ADEF = 9'h000;

    localparam csr_data_t TIMER_IDLE = 32'hffff_ffff;

    typedef struct packed {
        logic      we;
        csr_addr_t waddr;
        csr_data_t wmask;
        csr_data_t wdata;
    } csr_write_t;

    typedef struct packed {
        logic      ex;
        ecode_t    ecode;
        esubcode_t esubcode;
        csr_data_t pc;
        csr_data_t vaddr;
    } exc_event_t;

    typedef struct packed {
        plv_t            crmd_plv;
        logic            crmd_ie;
        logic            crmd_da;
        logic            crmd_pg;
        logic [1:0]      crmd_datf;
        logic [1:0]      crmd_datm;
        plv_t            prmd_pplv;
        logic            prmd_pie;
        ecode_t          estat_ecode;
        esubcode_t       estat_esubcode;
        csr_data_t       era;
        csr_data_t       badv;
        logic [25:0]     eentry_va;
        csr_data_t [3:0] save;
    } exc_view_t;

    typedef struct packed {
        int_vec_t ecfg_lie;
        int_vec_t estat_is;
    } int_view_t;

    typedef struct packed {
        csr_data_t   tid;
        logic        tcfg_en;
        logic        tcfg_periodic;
        logic [29:0] tcfg_initval;
        csr_data_t   tval;
    } timer_view_t;

    // Old value where the mask is 0, new data where it is 1
    function automatic csr_data_t csr_merge(csr_data_t old_val, csr_write_t w);
        return (w.wmask & w.wdata) | (~w.wmask & old_val);
    endfunction

    function automatic logic csr_hit(csr_write_t w, csr_addr_t addr);
        return w.we && (w.waddr == addr);
    endfunction

endpackage

/* rtl/csr_exc_regs.sv */
`timescale 1ns/1ps

module csr_exc_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_write_t  csr_write,
    input  csr_pkg::exc_event_t  wb_exc,
    input  logic                 ertn_flush,
    output logic                 crmd_ie,
    output csr_pkg::csr_data_t   ex_entry,
    output csr_pkg::exc_view_t   view
);
    import csr_pkg::*;

    plv_t            crmd_plv;
    logic            crmd_da;
    logic            crmd_pg;
    logic [1:0]      crmd_datf;
    logic [1:0]      crmd_datm;
    plv_t            prmd_pplv;
    logic            prmd_pie;
    ecode_t          estat_ecode;
    esubcode_t       estat_esubcode;
    csr_data_t       era;
    csr_data_t       badv;
    logic [25:0]     eentry_va;
    csr_data_t [3:0] save;
    csr_data_t       crmd_new;
    csr_data_t       prmd_new;
    csr_data_t       eentry_new;
    logic            addr_err;

    assign crmd_new = csr_merge({23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie,
                                 crmd_plv}, csr_write);
    assign prmd_new = csr_merge({29'b0, prmd_pie, prmd_pplv}, csr_write);
    assign eentry_new = csr_merge(ex_entry, csr_write);

    // Exception first, then ertn, then a CSR write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (wb_exc.ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_hit(csr_write, CSR_CRMD)) begin
            crmd_plv  <= crmd_new[CRMD_PLV_HI:CRMD_PLV_LO];
            crmd_ie   <= crmd_new[CRMD_IE];
            crmd_da   <= crmd_new[CRMD_DA];
            crmd_pg   <= crmd_new[CRMD_PG];
            crmd_datf <= crmd_new[CRMD_DATF_HI:CRMD_DATF_LO];
            crmd_datm <= crmd_new[CRMD_DATM_HI:CRMD_DATM_LO];
        end
    end

    // Context saved on exception entry
    always_ff @(posedge clk) begin
        if (wb_exc.ex) begin
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            estat_ecode    <= wb_exc.ecode;
            estat_esubcode <= wb_exc.esubcode;
            era            <= wb_exc.pc;
        end else begin
            if (csr_hit(csr_write, CSR_PRMD)) begin
                prmd_pplv <= prmd_new[PRMD_PPLV_HI:PRMD_PPLV_LO];
                prmd_pie  <= prmd_new[PRMD_PIE];
            end
            if (csr_hit(csr_write, CSR_ERA)) begin
                era <= csr_merge(era, csr_write);
            end
        end
    end

    assign addr_err = (wb_exc.ecode == ECODE_ADE) || (wb_exc.ecode == ECODE_ALE);

    // Fetch address errors report the pc itself
    always_ff @(posedge clk) begin
        if (wb_exc.ex && addr_err) begin
            if (wb_exc.ecode == ECODE_ADE && wb_exc.esubcode == ESUBCODE_ADEF) begin
                badv <= wb_exc.pc;
            end else begin
                badv <= wb_exc.vaddr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (csr_hit(csr_write, CSR_EENTRY)) begin
            eentry_va <= eentry_new[EENTRY_VA_HI:EENTRY_VA_LO];
        end
        if (csr_hit(csr_write, CSR_SAVE0)) begin
            save[0] <= csr_merge(save[0], csr_write);
        end
        if (csr_hit(csr_write, CSR_SAVE1)) begin
            save[1] <= csr_merge(save[1], csr_write);
        end
        if (csr_hit(csr_write, CSR_SAVE2)) begin
            save[2] <= csr_merge(save[2], csr_write);
        end
        if (csr_hit(csr_write, CSR_SAVE3)) begin
            save[3] <= csr_merge(save[3], csr_write);
        end
    end

    assign ex_entry = {eentry_va, 6'b0};

    always_comb begin
        view.crmd_plv       = crmd_plv;
        view.crmd_ie        = crmd_ie;
        view.crmd_da        = crmd_da;
        view.crmd_pg        = crmd_pg;
        view.crmd_datf      = crmd_datf;
        view.crmd_datm      = crmd_datm;
        view.prmd_pplv      = prmd_pplv;
        view.prmd_pie       = prmd_pie;
        view.estat_ecode    = estat_ecode;
        view.estat_esubcode = estat_esubcode;
        view.era            = era;
        view.badv           = badv;
        view.eentry_va      = eentry_va;
        view.save           = save;
    end

endmodule

/* rtl/csr_int_ctrl.sv */
`timescale 1ns/1ps

module csr_int_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_write_t csr_write,
    input  logic [7:0]          hw_int_in,
    input  logic                ipi_int_in,
    input  logic                timer_zero,
    input  logic                crmd_ie,
    output logic                has_int,
    output csr_pkg::int_view_t  view
);
    import csr_pkg::*;

    int_vec_t                  ecfg_lie;
    logic [IS_SW_HI:0]         is_sw;
    logic [IS_HW_HI:IS_HW_LO]  is_hw;
    logic                      is_timer;
    logic                      is_ipi;
    int_vec_t                  is_vec;
    csr_data_t                 ecfg_new;
    csr_data_t                 estat_new;
    logic                      ticlr;

    assign ecfg_new  = csr_merge(csr_data_t'(ecfg_lie), csr_write);
    assign estat_new = csr_merge(csr_data_t'(is_sw), csr_write);
    assign ticlr     = csr_hit(csr_write, CSR_TICLR) && csr_write.wmask[TICLR_CLR]
                       && csr_write.wdata[TICLR_CLR];

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            is_sw    <= '0;
            is_timer <= 1'b0;
        end else begin
            if (csr_hit(csr_write, CSR_ECFG)) begin
                ecfg_lie <= ecfg_new[ECFG_LIE_HI:0] & ECFG_LIE_MASK;
            end
            if (csr_hit(csr_write, CSR_ESTAT)) begin
                is_sw <= estat_new[IS_SW_HI:0];
            end
            // Timer bit is sticky until software clears it
            if (timer_zero) begin
                is_timer <= 1'b1;
            end else if (ticlr) begin
                is_timer <= 1'b0;
            end
        end
    end

    // External lines are sampled every cycle
    always_ff @(posedge clk) begin
        is_hw  <= hw_int_in;
        is_ipi <= ipi_int_in;
    end

    always_comb begin
        is_vec                    = '0;
        is_vec[IS_SW_HI:0]        = is_sw;
        is_vec[IS_HW_HI:IS_HW_LO] = is_hw;
        is_vec[IS_TIMER]          = is_timer;
        is_vec[IS_IPI]            = is_ipi;
    end

    assign has_int = (|(is_vec & ecfg_lie)) && crmd_ie;

    assign view.ecfg_lie = ecfg_lie;
    assign view.estat_is = is_vec;

endmodule

/* rtl/csr_timer.sv */
`timescale 1ns/1ps

module csr_timer (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_write_t  csr_write,
    input  csr_pkg::csr_data_t   coreid_in,
    output logic                 timer_zero,
    output csr_pkg::timer_view_t view
);
    import csr_pkg::*;

    csr_data_t   tid;
    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    csr_data_t   timer_cnt;
    csr_data_t   tcfg_next;
    logic        tcfg_we;

    assign tcfg_we   = csr_hit(csr_write, CSR_TCFG);
    assign tcfg_next = csr_merge({tcfg_initval, tcfg_periodic, tcfg_en}, csr_write);

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= coreid_in;
        end else if (csr_hit(csr_write, CSR_TID)) begin
            tid <= csr_merge(tid, csr_write);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en <= 1'b0;
        end else if (tcfg_we) begin
            tcfg_en <= tcfg_next[TCFG_EN];
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_we) begin
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC];
            tcfg_initval  <= tcfg_next[TCFG_INITV_HI:TCFG_INITV_LO];
        end
    end

    // Countdown in units of four cycles of initval
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= TIMER_IDLE;
        end else if (tcfg_we && tcfg_next[TCFG_EN]) begin
            timer_cnt <= {tcfg_next[TCFG_INITV_HI:TCFG_INITV_LO], 2'b0};
        end else if (tcfg_en && timer_cnt != TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b0};
            end else begin
                // One-shot wraps from 0 to idle and parks there
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    assign timer_zero = (timer_cnt == '0);

    always_comb begin
        view.tid           = tid;
        view.tcfg_en       = tcfg_en;
        view.tcfg_periodic = tcfg_periodic;
        view.tcfg_initval  = tcfg_initval;
        view.tval          = timer_cnt;
    end

endmodule

/* rtl/csr_read_mux.sv */
`timescale 1ns/1ps

module csr_read_mux (
    input  csr_pkg::csr_addr_t   csr_raddr,
    input  csr_pkg::exc_view_t   exc,
    input  csr_pkg::int_view_t   ints,
    input  csr_pkg::timer_view_t timer,
    output csr_pkg::csr_data_t   csr_rdata
);
    import csr_pkg::*;

    csr_data_t crmd_word;
    csr_data_t prmd_word;
    csr_data_t estat_word;
    csr_data_t eentry_word;
    csr_data_t tcfg_word;

    // Reserved bits read as zero
    always_comb begin
        crmd_word                             = '0;
        crmd_word[CRMD_PLV_HI:CRMD_PLV_LO]    = exc.crmd_plv;
        crmd_word[CRMD_IE]                    = exc.crmd_ie;
        crmd_word[CRMD_DA]                    = exc.crmd_da;
        crmd_word[CRMD_PG]                    = exc.crmd_pg;
        crmd_word[CRMD_DATF_HI:CRMD_DATF_LO]  = exc.crmd_datf;
        crmd_word[CRMD_DATM_HI:CRMD_DATM_LO]  = exc.crmd_datm;

        prmd_word                             = '0;
        prmd_word[PRMD_PPLV_HI:PRMD_PPLV_LO]  = exc.prmd_pplv;
        prmd_word[PRMD_PIE]                   = exc.prmd_pie;

        estat_word                                = csr_data_t'(ints.estat_is);
        estat_word[ESTAT_ECODE_HI:ESTAT_ECODE_LO] = exc.estat_ecode;
        estat_word[ESTAT_ESUB_HI:ESTAT_ESUB_LO]   = exc.estat_esubcode;

        eentry_word                             = '0;
        eentry_word[EENTRY_VA_HI:EENTRY_VA_LO]  = exc.eentry_va;

        tcfg_word                               = '0;
        tcfg_word[TCFG_EN]                      = timer.tcfg_en;
        tcfg_word[TCFG_PERIODIC]                = timer.tcfg_periodic;
        tcfg_word[TCFG_INITV_HI:TCFG_INITV_LO]  = timer.tcfg_initval;
    end

    always_comb begin
        case (csr_raddr)
            CSR_CRMD:   csr_rdata = crmd_word;
            CSR_PRMD:   csr_rdata = prmd_word;
            CSR_ECFG:   csr_rdata = csr_data_t'(ints.ecfg_lie);
            CSR_ESTAT:  csr_rdata = estat_word;
            CSR_ERA:    csr_rdata = exc.era;
            CSR_BADV:   csr_rdata = exc.badv;
            CSR_EENTRY: csr_rdata = eentry_word;
            CSR_SAVE0:  csr_rdata = exc.save[0];
            CSR_SAVE1:  csr_rdata = exc.save[1];
            CSR_SAVE2:  csr_rdata = exc.save[2];
            CSR_SAVE3:  csr_rdata = exc.save[3];
            CSR_TID:    csr_rdata = timer.tid;
            CSR_TCFG:   csr_rdata = tcfg_word;
            CSR_TVAL:   csr_rdata = timer.tval;
            // Clear bit is write-only
            CSR_TICLR:  csr_rdata = '0;
            default:    csr_rdata = '0;
        endcase
    end

endmodule

/* rtl/csr_regfile.sv */
`timescale 1ns/1ps

module csr_regfile (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_write_t csr_write,
    input  csr_pkg::csr_addr_t  csr_raddr,
    output csr_pkg::csr_data_t  csr_rdata,
    input  csr_pkg::exc_event_t wb_exc,
    input  logic                ertn_flush,
    input  logic [7:0]          hw_int_in,
    input  logic                ipi_int_in,
    input  csr_pkg::csr_data_t  coreid_in,
    output logic                has_int,
    output csr_pkg::csr_data_t  ex_entry
);
    import csr_pkg::*;

    logic        crmd_ie;
    logic        timer_zero;
    exc_view_t   exc_view;
    int_view_t   int_view;
    timer_view_t timer_view;

    csr_exc_regs u_exc_regs (
        .clk        (clk),
        .reset      (reset),
        .csr_write  (csr_write),
        .wb_exc     (wb_exc),
        .ertn_flush (ertn_flush),
        .crmd_ie    (crmd_ie),
        .ex_entry   (ex_entry),
        .view       (exc_view)
    );

    csr_int_ctrl u_int_ctrl (
        .clk        (clk),
        .reset      (reset),
        .csr_write  (csr_write),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .timer_zero (timer_zero),
        .crmd_ie    (crmd_ie),
        .has_int    (has_int),
        .view       (int_view)
    );

    csr_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_write  (csr_write),
        .coreid_in  (coreid_in),
        .timer_zero (timer_zero),
        .view       (timer_view)
    );

    // Combinational read of all groups
    csr_read_mux u_read_mux (
        .csr_raddr (csr_raddr),
        .exc       (exc_view),
        .ints      (int_view),
        .timer     (timer_view),
        .csr_rdata (csr_rdata)
    );

endmodule

/* tb/csr_regfile_tb.sv */
`timescale 1ns/1ps

module csr_regfile_tb;
    import csr_pkg::*;

    localparam int        CLK_PERIOD   = 40;
    localparam int        RESET_CYCLES = 3;
    localparam int        SEED         = 84;
    localparam int        WAIT_LIMIT   = 40;
    localparam csr_data_t COREID       = 32'h0000_0005;
    localparam csr_data_t ALL_ONES     = 32'hffff_ffff;
    localparam ecode_t    ECODE_SYS    = 6'h0b;

    logic       clk;
    logic       reset;
    csr_write_t csr_write;
    csr_addr_t  csr_raddr;
    csr_data_t  csr_rdata;
    exc_event_t wb_exc;
    logic       ertn_flush;
    logic [7:0] hw_int_in;
    logic       ipi_int_in;
    csr_data_t  coreid_in;
    logic       has_int;
    csr_data_t  ex_entry;

    int checks;
    int errors;
    int case_start;

    csr_regfile dut (
        .clk        (clk),
        .reset      (reset),
        .csr_write  (csr_write),
        .csr_raddr  (csr_raddr),
        .csr_rdata  (csr_rdata),
        .wb_exc     (wb_exc),
        .ertn_flush (ertn_flush),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .coreid_in  (coreid_in),
        .has_int    (has_int),
        .ex_entry   (ex_entry)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_eq(input string what, input csr_data_t got, input csr_data_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s", $time, what);
        end
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_data_t mask, input csr_data_t data);
        @(posedge clk);
        csr_write.we    <= 1'b1;
        csr_write.waddr <= addr;
        csr_write.wmask <= mask;
        csr_write.wdata <= data;
        @(posedge clk);
        csr_write.we    <= 1'b0;
    endtask

    // Sampled mid-cycle, after the address has settled
    task automatic read_csr(input csr_addr_t addr, output csr_data_t data);
        @(posedge clk);
        csr_raddr <= addr;
        @(negedge clk);
        data = csr_rdata;
    endtask

    task automatic raise_exception(input ecode_t ecode, input esubcode_t esub,
                                   input csr_data_t pc, input csr_data_t vaddr);
        @(posedge clk);
        wb_exc.ex       <= 1'b1;
        wb_exc.ecode    <= ecode;
        wb_exc.esubcode <= esub;
        wb_exc.pc       <= pc;
        wb_exc.vaddr    <= vaddr;
        @(posedge clk);
        wb_exc.ex       <= 1'b0;
    endtask

    task automatic wait_has_int(input logic exp, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (has_int !== exp && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (has_int !== exp) begin
            errors++;
            $display("Timed out after %0d cycles waiting for has_int = %0b (%s)", n, exp, what);
        end
    endtask

    task automatic wait_estat_bit(input int bit_pos, input logic exp, input string what);
        csr_data_t val;
        int        n;
        n = 0;
        read_csr(CSR_ESTAT, val);
        while (val[bit_pos] !== exp && n < WAIT_LIMIT) begin
            read_csr(CSR_ESTAT, val);
            n++;
        end
        if (val[bit_pos] !== exp) begin
            errors++;
            $display("Timed out after %0d reads waiting for ESTAT bit %0d (%s)", n, bit_pos, what);
        end
    endtask

    task automatic check_masked(input csr_addr_t addr, input string name);
        csr_data_t old_val;
        csr_data_t new_val;
        csr_data_t mask;
        csr_data_t got;
        old_val = $urandom();
        new_val = $urandom();
        mask    = $urandom();
        write_csr(addr, ALL_ONES, old_val);
        write_csr(addr, mask, new_val);
        read_csr(addr, got);
        check_eq(name, got, (old_val & ~mask) | (new_val & mask));
    endtask

    task automatic end_case(input string name);
        $display("%-16s %s", name, (errors == case_start) ? "ok" : "had errors");
        case_start = errors;
    endtask

    task automatic verify_reset_values();
        csr_data_t val;
        read_csr(CSR_CRMD, val);
        check_eq("CRMD after reset", val, 32'h8);
        read_csr(CSR_ECFG, val);
        check_eq("ECFG after reset", val, 32'h0);
        read_csr(CSR_TCFG, val);
        check_true("TCFG.en clear after reset", val[0] === 1'b0);
        read_csr(CSR_TVAL, val);
        check_eq("TVAL after reset", val, ALL_ONES);
        read_csr(CSR_TID, val);
        check_eq("TID after reset", val, COREID);
        check_true("has_int low after reset", has_int === 1'b0);
    endtask

    task automatic masked_write_readback();
        csr_data_t val;
        csr_data_t data;
        check_masked(CSR_SAVE0, "SAVE0 masked");
        check_masked(CSR_SAVE1, "SAVE1 masked");
        check_masked(CSR_SAVE2, "SAVE2 masked");
        check_masked(CSR_SAVE3, "SAVE3 masked");
        check_masked(CSR_ERA, "ERA masked");
        write_csr(CSR_ECFG, ALL_ONES, ALL_ONES);
        read_csr(CSR_ECFG, val);
        check_eq("ECFG all ones", val, 32'h0000_1bff);
        data = $urandom();
        write_csr(CSR_EENTRY, ALL_ONES, data);
        read_csr(CSR_EENTRY, val);
        check_eq("EENTRY", val, data & 32'hffff_ffc0);
        check_eq("ex_entry", ex_entry, data & 32'hffff_ffc0);
        read_csr(14'h100, val);
        check_eq("unused address", val, 32'h0);
    endtask

    task automatic exception_and_ertn();
        csr_data_t val;
        csr_data_t pc;
        csr_data_t vaddr;
        csr_data_t fetch_pc;
        // PLV 3 with IE set
        write_csr(CSR_CRMD, 32'h7, 32'h7);
        pc    = $urandom() & 32'hffff_fffc;
        vaddr = $urandom();
        raise_exception(ECODE_ALE, 9'h000, pc, vaddr);
        read_csr(CSR_CRMD, val);
        check_eq("CRMD after ALE", val, 32'h8);
        read_csr(CSR_PRMD, val);
        check_eq("PRMD after ALE", val, 32'h7);
        read_csr(CSR_ERA, val);
        check_eq("ERA after ALE", val, pc);
        read_csr(CSR_BADV, val);
        check_eq("BADV after ALE", val, vaddr);
        read_csr(CSR_ESTAT, val);
        check_eq("ESTAT codes after ALE", val & 32'h7fff_0000, {1'b0, 9'h000, ECODE_ALE, 16'h0});
        fetch_pc = $urandom() & 32'hffff_fffc;
        raise_exception(ECODE_ADE, 9'h000, fetch_pc, $urandom());
        read_csr(CSR_BADV, val);
        check_eq("BADV after ADEF", val, fetch_pc);
        write_csr(CSR_CRMD, 32'h7, 32'h7);
        pc = $urandom() & 32'hffff_fffc;
        raise_exception(ECODE_SYS, 9'h000, pc, $urandom());
        read_csr(CSR_BADV, val);
        check_eq("BADV after SYS", val, fetch_pc);
        read_csr(CSR_ERA, val);
        check_eq("ERA after SYS", val, pc);
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
        read_csr(CSR_CRMD, val);
        check_eq("CRMD after ertn", val, 32'hf);
    endtask

    task automatic interrupt_sources();
        csr_data_t val;
        write_csr(CSR_ECFG, ALL_ONES, 32'h0000_0004);
        @(negedge clk);
        check_true("has_int low before hw line", has_int === 1'b0);
        @(posedge clk);
        hw_int_in <= 8'h01;
        wait_has_int(1'b1, "hw line 0");
        read_csr(CSR_ESTAT, val);
        check_true("ESTAT bit 2 set", val[2] === 1'b1);
        write_csr(CSR_CRMD, 32'h4, 32'h0);
        wait_has_int(1'b0, "IE cleared");
        @(posedge clk);
        hw_int_in <= 8'h00;
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        write_csr(CSR_ECFG, ALL_ONES, 32'h0000_0002);
        write_csr(CSR_ESTAT, 32'h3, 32'h2);
        wait_has_int(1'b1, "software bit 1");
        write_csr(CSR_ESTAT, 32'h3, 32'h0);
        wait_has_int(1'b0, "software bit 1 cleared");
        write_csr(CSR_ECFG, ALL_ONES, 32'h0000_1000);
        @(posedge clk);
        ipi_int_in <= 1'b1;
        wait_has_int(1'b1, "IPI");
        @(posedge clk);
        ipi_int_in <= 1'b0;
        wait_has_int(1'b0, "IPI dropped");
    endtask

    task automatic timer_countdown();
        csr_data_t prev;
        csr_data_t cur;
        int        n;
        write_csr(CSR_ECFG, ALL_ONES, 32'h0);
        // en, one-shot, initval 3
        write_csr(CSR_TCFG, ALL_ONES, 32'h0000_000d);
        read_csr(CSR_TVAL, prev);
        check_true("TVAL starts at or below 12", prev <= 32'd12);
        cur = prev;
        n = 0;
        while (cur != ALL_ONES && n < WAIT_LIMIT) begin
            read_csr(CSR_TVAL, cur);
            if (cur != ALL_ONES) begin
                check_true("TVAL never increases", cur <= prev);
            end
            prev = cur;
            n++;
        end
        if (cur != ALL_ONES) begin
            errors++;
            $display("Timed out after %0d reads waiting for the one-shot timer to stop", n);
        end
        wait_estat_bit(IS_TIMER, 1'b1, "one-shot expiry");
        read_csr(CSR_TVAL, cur);
        check_eq("TVAL after one-shot", cur, ALL_ONES);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT, cur);
        check_true("TICLR clears bit 11", cur[IS_TIMER] === 1'b0);
        // en, periodic, initval 3
        write_csr(CSR_TCFG, ALL_ONES, 32'h0000_000f);
        wait_estat_bit(IS_TIMER, 1'b1, "first periodic expiry");
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT, cur);
        check_true("TICLR clears bit 11 in periodic mode", cur[IS_TIMER] === 1'b0);
        wait_estat_bit(IS_TIMER, 1'b1, "second periodic expiry");
        read_csr(CSR_TVAL, cur);
        check_true("periodic TVAL at or below 12", cur <= 32'd12);
        write_csr(CSR_TCFG, ALL_ONES, 32'h0);
    endtask

    initial begin
        void'($urandom(SEED));
        checks     = 0;
        errors     = 0;
        case_start = 0;
        reset      = 1'b1;
        csr_write  = '0;
        csr_raddr  = '0;
        wb_exc     = '0;
        ertn_flush = 1'b0;
        hw_int_in  = 8'h00;
        ipi_int_in = 1'b0;
        coreid_in  = COREID;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        verify_reset_values();
        end_case("reset_values");
        masked_write_readback();
        end_case("masked_writes");
        exception_and_ertn();
        end_case("exception_ertn");
        interrupt_sources();
        end_case("interrupts");
        timer_countdown();
        end_case("timer");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
rtl/csr_pkg.sv
rtl/csr_exc_regs.sv
rtl/csr_int_ctrl.sv
rtl/csr_timer.sv
rtl/csr_read_mux.sv
rtl/csr_regfile.sv
tb/csr_regfile_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= csr_regfile_tb
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test passed" $(LOG); then \
		echo "simulation result: PASS"; \
	else \
		echo "simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
